// ==== sim.f ====
src/lsu_pkg.sv
src/mem_req_if.sv
src/wait_timer.sv
src/store_align.sv
src/load_extend.sv
src/data_ram.sv
src/lsu_ctrl_fsm.sv
src/mem_stage_top.sv
tb/tb_clock.sv
tb/tb_mem_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/tb_mem_stage.sv ====
`timescale 1ns/1ps

module tb_mem_stage;
    import lsu_pkg::*;

    localparam int TIMEOUT = 50;
    localparam int EXP_W   = XLEN + REG_W + 2;

    logic             clk;
    logic             arst_n;
    logic             flush;
    logic             in_valid;
    logic             in_ready;
    mem_op_t          in_op;
    logic [XLEN-1:0]  in_addr;
    logic [XLEN-1:0]  in_wdata;
    logic [REG_W-1:0] in_rd;
    logic             in_wen;
    logic             out_valid;
    logic             out_ready;
    logic [XLEN-1:0]  out_result;
    logic [REG_W-1:0] out_rd;
    logic             out_wen;
    logic             out_excp;

    // reference byte memory and expected results {result, rd, wen, excp}
    logic [7:0]       mem_ref [4*RAM_DEPTH];
    logic [EXP_W-1:0] exp_q [$];
    logic [15:0]      lfsr = 16'd35;
    logic             quiet;
    logic             hold;
    logic [EXP_W-1:0] held;

    tb_clock i_tb_clock (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    mem_stage_top i_mem_stage_top (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .flush_i      (flush),
        .in_valid_i   (in_valid),
        .in_ready_o   (in_ready),
        .in_op_i      (in_op),
        .in_addr_i    (in_addr),
        .in_wdata_i   (in_wdata),
        .in_rd_i      (in_rd),
        .in_wen_i     (in_wen),
        .out_valid_o  (out_valid),
        .out_ready_i  (out_ready),
        .out_result_o (out_result),
        .out_rd_o     (out_rd),
        .out_wen_o    (out_wen),
        .out_excp_o   (out_excp)
    );

    task automatic stop_with_failure(string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic value_fail(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
        stop_with_failure($sformatf("[FAIL] t=%0t %s expected %h actual %h",
                                    $time, name, exp, act));
    endtask

    // galois lfsr, one step per bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr >> 1;
            if (v[i]) begin
                lfsr = lfsr ^ 16'hB400;
            end
        end
        return v;
    endfunction

    // expected output for one accepted op, updates the reference memory
    function automatic logic [EXP_W-1:0] expect_for(mem_op_t op, logic [XLEN-1:0] a,
                                                   logic [XLEN-1:0] d, logic [REG_W-1:0] rd,
                                                   logic wen);
        logic            bad;
        logic [XLEN-1:0] res;
        int              b;
        int              nb;
        // access width in bytes, the address must be a multiple of it
        nb  = (op.size == SZ_WORD) ? 4 : ((op.size == SZ_HALF) ? 2 : 1);
        bad = op.is_mem && ((int'(a[1:0]) % nb) != 0);
        res = a;
        b   = int'(a[9:0]);
        if (op.is_mem && !bad) begin
            if (op.is_store) begin
                for (int i = 0; i < nb; i++) begin
                    mem_ref[b+i] = d[8*i +: 8];
                end
            end else if (op.size == SZ_BYTE) begin
                res = {{24{mem_ref[b][7] & !op.is_unsigned}}, mem_ref[b]};
            end else if (op.size == SZ_HALF) begin
                res = {{16{mem_ref[b+1][7] & !op.is_unsigned}}, mem_ref[b+1], mem_ref[b]};
            end else begin
                res = {mem_ref[b+3], mem_ref[b+2], mem_ref[b+1], mem_ref[b]};
            end
        end
        return {res, rd, wen && !bad, bad};
    endfunction

    always @(posedge clk) begin
        logic [EXP_W-1:0] e;
        if (!arst_n) begin
            quiet <= 1'b1;
            hold  <= 1'b0;
        end else begin
            // held output must not move
            if (hold) begin
                assert (out_valid) else stop_with_failure("out_valid_o dropped while held");
                assert (out_result == held[EXP_W-1 -: XLEN])
                    else value_fail("out_result_o", held[EXP_W-1 -: XLEN], out_result);
                assert ({out_rd, out_wen, out_excp} == held[REG_W+1:0])
                    else value_fail("out_rd_o/out_wen_o/out_excp_o",
                                    XLEN'(held[REG_W+1:0]), XLEN'({out_rd, out_wen, out_excp}));
            end
            assert (!(quiet && out_valid))
                else stop_with_failure("out_valid_o high with no op accepted since reset or flush");
            if (flush) begin
                exp_q.delete();
                quiet <= 1'b1;
                hold  <= 1'b0;
            end else begin
                if (out_valid && out_ready) begin
                    if (exp_q.size() == 0) begin
                        stop_with_failure("a result appeared that no accepted op explains");
                    end
                    e = exp_q.pop_front();
                    assert (out_result == e[EXP_W-1 -: XLEN])
                        else value_fail("out_result_o", e[EXP_W-1 -: XLEN], out_result);
                    assert (out_rd == e[REG_W+1:2])
                        else value_fail("out_rd_o", XLEN'(e[REG_W+1:2]), XLEN'(out_rd));
                    assert (out_wen == e[1])
                        else value_fail("out_wen_o", XLEN'(e[1]), XLEN'(out_wen));
                    assert (out_excp == e[0])
                        else value_fail("out_excp_o", XLEN'(e[0]), XLEN'(out_excp));
                end
                if (in_valid && in_ready) begin
                    exp_q.push_back(expect_for(in_op, in_addr, in_wdata, in_rd, in_wen));
                    quiet <= 1'b0;
                end
                hold <= out_valid && !out_ready;
                held <= {out_result, out_rd, out_wen, out_excp};
            end
        end
    end

    task automatic send_op(mem_op_t op, logic [XLEN-1:0] a, logic [XLEN-1:0] d);
        int n;
        in_valid <= 1'b1;
        in_op    <= op;
        in_addr  <= a;
        in_wdata <= d;
        in_rd    <= REG_W'(take_bits(REG_W));
        in_wen   <= 1'(take_bits(1));
        n = 0;
        @(posedge clk);
        while (!in_ready) begin
            n++;
            if (n > TIMEOUT) begin
                stop_with_failure("timed out waiting for in_ready_o");
            end
            @(posedge clk);
        end
        in_valid <= 1'b0;
    endtask

    // aligned op in the first 16 words so loads hit earlier stores
    task automatic send_aligned(logic st);
        mem_op_t     op;
        logic [31:0] a;
        op.is_mem      = 1'b1;
        op.is_store    = st;
        op.size        = 2'(take_bits(2));
        op.is_unsigned = 1'(take_bits(1));
        if (op.size == 2'd3) begin
            op.size = SZ_WORD;
        end
        a = {26'd0, 4'(take_bits(4)), 2'b00};
        if (op.size == SZ_BYTE) begin
            a[1:0] = 2'(take_bits(2));
        end else if (op.size == SZ_HALF) begin
            a[1] = 1'(take_bits(1));
        end
        send_op(op, a, take_bits(32));
    endtask

    task automatic drain();
        int n;
        n = 0;
        // the last transfer is queued by the checker on its own edge
        @(posedge clk);
        while (exp_q.size() != 0) begin
            n++;
            if (n > TIMEOUT) begin
                stop_with_failure("timed out waiting for expected results");
            end
            @(posedge clk);
        end
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        repeat (10) @(posedge clk);
    endtask

    initial begin
        int n;
        flush     = 1'b0;
        in_valid  = 1'b0;
        in_op     = '0;
        in_addr   = '0;
        in_wdata  = '0;
        in_rd     = '0;
        in_wen    = 1'b0;
        out_ready = 1'b0;
        for (int i = 0; i < 4*RAM_DEPTH; i++) begin
            mem_ref[i] = 8'h00;
        end
        n = 0;
        while (!arst_n) begin
            n++;
            if (n > 20) begin
                stop_with_failure("reset was never released");
            end
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        assert (in_ready) else stop_with_failure("in_ready_o low after reset");
        out_ready <= 1'b1;

        for (int i = 0; i < 24; i++) begin
            send_aligned(1'b1);
        end
        for (int i = 0; i < 32; i++) begin
            send_aligned(1'b0);
        end
        drain();

        // misaligned accesses, then read back the same word
        send_op('{1'b1, 1'b1, SZ_WORD, 1'b0}, 32'h16, 32'hDEADBEEF);
        send_op('{1'b1, 1'b1, SZ_HALF, 1'b0}, 32'h15, 32'hCAFEF00D);
        send_op('{1'b1, 1'b0, SZ_HALF, 1'b1}, 32'h21, 32'h0);
        send_op('{1'b1, 1'b0, SZ_WORD, 1'b0}, 32'h14, 32'h0);
        drain();

        for (int i = 0; i < 3; i++) begin
            send_op('0, take_bits(32), 32'h0);
        end
        drain();

        // back-pressure, the load finishes behind a waiting result
        out_ready <= 1'b0;
        send_op('0, take_bits(32), 32'h0);
        send_aligned(1'b0);
        repeat (12) @(posedge clk);
        out_ready <= 1'b1;
        drain();

        // flush with a full output register and an op waiting
        out_ready <= 1'b0;
        send_aligned(1'b0);
        send_op('0, take_bits(32), 32'h0);
        pulse_flush();
        out_ready <= 1'b1;

        // flush after the store request, the write still lands
        send_op('{1'b1, 1'b1, SZ_WORD, 1'b0}, 32'h40, take_bits(32));
        pulse_flush();
        send_op('{1'b1, 1'b0, SZ_WORD, 1'b0}, 32'h40, 32'h0);
        drain();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic arst_n_o
);

    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // held in reset for three rising edges, released away from the edge
    initial begin
        arst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

// ==== src/mem_stage_top.sv ====
`timescale 1ns/1ps

module mem_stage_top (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      flush_i,
    input  logic                      in_valid_i,
    output logic                      in_ready_o,
    input  lsu_pkg::mem_op_t          in_op_i,
    input  logic [lsu_pkg::XLEN-1:0]  in_addr_i,
    input  logic [lsu_pkg::XLEN-1:0]  in_wdata_i,
    input  logic [lsu_pkg::REG_W-1:0] in_rd_i,
    input  logic                      in_wen_i,
    output logic                      out_valid_o,
    input  logic                      out_ready_i,
    output logic [lsu_pkg::XLEN-1:0]  out_result_o,
    output logic [lsu_pkg::REG_W-1:0] out_rd_o,
    output logic                      out_wen_o,
    output logic                      out_excp_o
);
    import lsu_pkg::*;

    mem_op_t         cur_op;
    logic [XLEN-1:0] cur_addr;
    logic [XLEN-1:0] cur_wdata;
    logic [XLEN-1:0] ld_data;

    mem_req_if mem_bus ();

    lsu_ctrl_fsm i_lsu_ctrl_fsm (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_op_i      (in_op_i),
        .in_addr_i    (in_addr_i),
        .in_wdata_i   (in_wdata_i),
        .in_rd_i      (in_rd_i),
        .in_wen_i     (in_wen_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_result_o (out_result_o),
        .out_rd_o     (out_rd_o),
        .out_wen_o    (out_wen_o),
        .out_excp_o   (out_excp_o),
        .ld_data_i    (ld_data),
        .cur_op_o     (cur_op),
        .cur_addr_o   (cur_addr),
        .cur_wdata_o  (cur_wdata),
        .mem          (mem_bus.master)
    );

    store_align i_store_align (
        .op_i      (cur_op),
        .addr_lo_i (cur_addr[1:0]),
        .data_i    (cur_wdata),
        .mem       (mem_bus.wr)
    );

    load_extend i_load_extend (
        .op_i      (cur_op),
        .addr_lo_i (cur_addr[1:0]),
        .data_o    (ld_data),
        .mem       (mem_bus.rd)
    );

    data_ram i_data_ram (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .mem      (mem_bus.slave)
    );

endmodule

// ==== src/lsu_ctrl_fsm.sv ====
`timescale 1ns/1ps

module lsu_ctrl_fsm (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          flush_i,
    input  logic                          in_valid_i,
    output logic                          in_ready_o,
    input  lsu_pkg::mem_op_t              in_op_i,
    input  logic [lsu_pkg::XLEN-1:0]      in_addr_i,
    input  logic [lsu_pkg::XLEN-1:0]      in_wdata_i,
    input  logic [lsu_pkg::REG_W-1:0]     in_rd_i,
    input  logic                          in_wen_i,
    output logic                          out_valid_o,
    input  logic                          out_ready_i,
    output logic [lsu_pkg::XLEN-1:0]      out_result_o,
    output logic [lsu_pkg::REG_W-1:0]     out_rd_o,
    output logic                          out_wen_o,
    output logic                          out_excp_o,
    input  logic [lsu_pkg::XLEN-1:0]      ld_data_i,
    output lsu_pkg::mem_op_t              cur_op_o,
    output logic [lsu_pkg::XLEN-1:0]      cur_addr_o,
    output logic [lsu_pkg::XLEN-1:0]      cur_wdata_o,
    mem_req_if.master                     mem
);
    import lsu_pkg::*;

    st_t              state;
    st_t              state_nxt;
    mem_op_t          cur_op;
    logic [XLEN-1:0]  cur_addr;
    logic [XLEN-1:0]  cur_wdata;
    logic [REG_W-1:0] cur_rd;
    logic             cur_wen;
    logic             cur_excp;
    logic             in_fire;
    logic             misalign;
    logic             tmr_done;
    logic             ack_seen;
    logic             res_ok;
    logic             out_load;

    // no new op while a flush is in progress
    assign in_ready_o = (state == IDLE) && !flush_i;
    assign in_fire    = in_valid_i && in_ready_o;

    assign misalign = in_op_i.is_mem &&
                      (((in_op_i.size == SZ_HALF) && in_addr_i[0]) ||
                       ((in_op_i.size == SZ_WORD) && (in_addr_i[1:0] != 2'b00)));

    assign mem.req  = (state == ACCESS);
    assign mem.we   = cur_op.is_store;
    assign mem.addr = cur_addr[RAM_AW+1:2];

    // own copy of the wait-state count, ends WAIT
    wait_timer i_wait_timer (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .start_i  (mem.req),
        .done_o   (tmr_done),
        .busy_o   ()
    );

    // result ready: no access needed, or the RAM has answered
    assign res_ok   = !cur_op.is_mem || cur_excp || mem.ack || ack_seen;
    assign out_load = (state == DONE) && res_ok && (!out_valid_o || out_ready_i);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (in_fire) begin
                    state_nxt = (in_op_i.is_mem && !misalign) ? ACCESS : DONE;
                end
            end
            ACCESS: state_nxt = WAIT;
            WAIT: begin
                if (tmr_done) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                if (out_load) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
        if (flush_i) begin
            state_nxt = IDLE;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state       <= IDLE;
            ack_seen    <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            state <= state_nxt;
            // ack is a single pulse, remember it under back-pressure
            if (flush_i || out_load) begin
                ack_seen <= 1'b0;
            end else if ((state == DONE) && mem.ack) begin
                ack_seen <= 1'b1;
            end
            if (flush_i) begin
                out_valid_o <= 1'b0;
            end else if (out_load) begin
                out_valid_o <= 1'b1;
            end else if (out_ready_i) begin
                out_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            cur_op    <= in_op_i;
            cur_addr  <= in_addr_i;
            cur_wdata <= in_wdata_i;
            cur_rd    <= in_rd_i;
            cur_wen   <= in_wen_i;
            cur_excp  <= misalign;
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            // loads return memory data, everything else the address
            if (cur_op.is_mem && !cur_op.is_store && !cur_excp) begin
                out_result_o <= ld_data_i;
            end else begin
                out_result_o <= cur_addr;
            end
            out_rd_o   <= cur_rd;
            out_wen_o  <= cur_wen && !cur_excp;
            out_excp_o <= cur_excp;
        end
    end

    assign cur_op_o    = cur_op;
    assign cur_addr_o  = cur_addr;
    assign cur_wdata_o = cur_wdata;

endmodule

// ==== src/data_ram.sv ====
`timescale 1ns/1ps

module data_ram (
    input  logic     clk,
    input  logic     arst_n_i,
    mem_req_if.slave mem
);
    import lsu_pkg::*;

    logic [XLEN-1:0] ram [RAM_DEPTH];
    logic [XLEN-1:0] rdata_q;
    logic            ack_q;
    logic            tmr_done;

    initial begin
        for (int i = 0; i < RAM_DEPTH; i++) begin
            ram[i] = '0;
        end
    end

    // byte lane writes happen on the req edge
    always @(posedge clk) begin
        if (mem.req && mem.we) begin
            for (int b = 0; b < 4; b++) begin
                if (mem.wmask[b]) begin
                    ram[mem.addr][8*b +: 8] <= mem.wdata[8*b +: 8];
                end
            end
        end
    end

    // read word held until the next request
    always_ff @(posedge clk) begin
        if (mem.req) begin
            rdata_q <= ram[mem.addr];
        end
    end

    wait_timer i_ack_timer (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .start_i  (mem.req),
        .done_o   (tmr_done),
        .busy_o   ()
    );

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= tmr_done;
        end
    end

    assign mem.rdata = rdata_q;
    assign mem.ack   = ack_q;

endmodule

// ==== src/load_extend.sv ====
`timescale 1ns/1ps

module load_extend (
    input  lsu_pkg::mem_op_t         op_i,
    input  logic [1:0]               addr_lo_i,
    output logic [lsu_pkg::XLEN-1:0] data_o,
    mem_req_if.rd                    mem
);
    import lsu_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    always_comb begin
        case (addr_lo_i)
            2'd0:    byte_sel = mem.rdata[7:0];
            2'd1:    byte_sel = mem.rdata[15:8];
            2'd2:    byte_sel = mem.rdata[23:16];
            default: byte_sel = mem.rdata[31:24];
        endcase
        half_sel = addr_lo_i[1] ? mem.rdata[31:16] : mem.rdata[15:0];
    end

    always_comb begin
        case (op_i.size)
            SZ_BYTE: begin
                if (op_i.is_unsigned) begin
                    data_o = {{(XLEN-8){1'b0}}, byte_sel};
                end else begin
                    data_o = {{(XLEN-8){byte_sel[7]}}, byte_sel};
                end
            end
            SZ_HALF: begin
                if (op_i.is_unsigned) begin
                    data_o = {{(XLEN-16){1'b0}}, half_sel};
                end else begin
                    data_o = {{(XLEN-16){half_sel[15]}}, half_sel};
                end
            end
            default: data_o = mem.rdata;
        endcase
    end

endmodule

// ==== src/store_align.sv ====
`timescale 1ns/1ps

module store_align (
    input  lsu_pkg::mem_op_t        op_i,
    input  logic [1:0]              addr_lo_i,
    input  logic [lsu_pkg::XLEN-1:0] data_i,
    mem_req_if.wr                   mem
);
    import lsu_pkg::*;

    logic [XLEN-1:0] lane_data;
    logic [3:0]      lane_mask;

    always_comb begin
        lane_data = data_i;
        lane_mask = 4'b0000;
        case (op_i.size)
            SZ_BYTE: begin
                // byte copied to every lane, mask picks one
                lane_data = {4{data_i[7:0]}};
                lane_mask = 4'b0001 << addr_lo_i;
            end
            SZ_HALF: begin
                lane_data = {2{data_i[15:0]}};
                lane_mask = addr_lo_i[1] ? 4'b1100 : 4'b0011;
            end
            SZ_WORD: begin
                lane_mask = 4'b1111;
            end
            default: begin
                lane_mask = 4'b0000;
            end
        endcase
        // loads and non-memory ops never write
        if (!op_i.is_mem || !op_i.is_store) begin
            lane_mask = 4'b0000;
        end
    end

    assign mem.wdata = lane_data;
    assign mem.wmask = lane_mask;

endmodule

// ==== src/wait_timer.sv ====
`timescale 1ns/1ps

module wait_timer (
    input  logic clk,
    input  logic arst_n_i,
    input  logic start_i,
    output logic done_o,
    output logic busy_o
);
    import lsu_pkg::*;

    logic [TMR_W-1:0] cnt;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt    <= '0;
            busy_o <= 1'b0;
        end else if (start_i) begin
            // a new start reloads even while busy
            cnt    <= TMR_W'(WAIT_STATES);
            busy_o <= 1'b1;
        end else if (busy_o) begin
            if (cnt == '0) begin
                busy_o <= 1'b0;
            end else begin
                cnt <= cnt - TMR_W'(1);
            end
        end
    end

    assign done_o = busy_o && (cnt == '0);

endmodule

// ==== src/mem_req_if.sv ====
`timescale 1ns/1ps

interface mem_req_if;
    import lsu_pkg::*;

    logic              req;
    logic              we;
    logic [RAM_AW-1:0] addr;
    logic [3:0]        wmask;
    logic [XLEN-1:0]   wdata;
    logic [XLEN-1:0]   rdata;
    logic              ack;

    // FSM side, issues the access and watches for completion
    modport master (output req, output we, output addr, input ack);

    // store lane steering
    modport wr (output wdata, output wmask);

    modport slave (input req, input we, input addr, input wmask, input wdata,
                   output rdata, output ack);

    // load lane selection
    modport rd (input rdata);

endinterface

// ==== src/lsu_pkg.sv ====
package lsu_pkg;

    // datapath widths
    localparam int XLEN  = 32;
    localparam int REG_W = 5;

    // on-chip data RAM, 32-bit words
    localparam int RAM_DEPTH = 256;
    localparam int RAM_AW    = $clog2(RAM_DEPTH);

    // extra cycles the RAM needs before its answer is valid
    localparam int WAIT_STATES = 2;

    // wide enough to hold WAIT_STATES, never zero bits
    localparam int TMR_W = $clog2(WAIT_STATES + 2);

    // access size codes
    localparam logic [1:0] SZ_BYTE = 2'd0;
    localparam logic [1:0] SZ_HALF = 2'd1;
    localparam logic [1:0] SZ_WORD = 2'd2;

    // memory op as it arrives from execute
    typedef struct packed {
        logic       is_mem;
        logic       is_store;
        logic [1:0] size;
        logic       is_unsigned;
    } mem_op_t;

    // stage FSM
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        WAIT,
        DONE
    } st_t;

endpackage
